// ==== include/console_config.svh ====
// Console build constants
`ifndef CONSOLE_CONFIG_SVH
`define CONSOLE_CONFIG_SVH

`define KEY_FIFO_DEPTH 4     // Scan-code FIFO entries
`define TONE_HALF_PERIOD 50  // Clocks per half wave of the alarm

`define PIXEL_DIVIDE 4       // Clocks per pixel

`define H_VISIBLE 640        // Pixels
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

`define V_VISIBLE 480        // Lines
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

`define COLOR_PORT 8'h10     // Colour register address

`endif

// ==== verilog/keyboardPkg.sv ====
// Keyboard types
package keyboardPkg;

	typedef logic [7:0] scanCode;  // Raw make code

	// Bit 0 arrives first on the wire
	typedef struct packed {
		logic stop;      // Always 1 on a good frame
		logic parity;    // Odd over data
		scanCode data;   // LSB first
		logic start;     // Always 0 on a good frame
	} ps2Frame;

	// Start, stop and odd parity check
	function automatic logic frameValid(ps2Frame f);
		logic parityOk;
		parityOk = ^{f.data, f.parity};  // Odd count of ones
		return (f.start == 1'b0) && (f.stop == 1'b1) && parityOk;
	endfunction

endpackage

// ==== verilog/displayPkg.sv ====
// Display types
package displayPkg;

	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgbColor;

	typedef logic [9:0] hCount;  // Pixel column
	typedef logic [9:0] vCount;  // Line number

	// Processor colour format, RRRGGGBB
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} colorByte;

	// Widen each field by repeating its MSB
	function automatic rgbColor expandColor(colorByte c);
		rgbColor e;
		e.red = {c.red, c.red[2]};
		e.green = {c.green, c.green[2]};
		e.blue = {c.blue, c.blue[1], c.blue[1]};
		return e;
	endfunction

endpackage

// ==== verilog/ps2Receiver.sv ====
// PS/2 keyboard receiver
`timescale 1ns/1ps

module ps2Receiver (
	input logic CLK,
	input logic reset,
	input logic ps2c,                      // Keyboard clock
	input logic ps2Data,                   // Keyboard serial data
	output logic keyValid,                 // One-cycle pulse per good frame
	output keyboardPkg::scanCode keyCode
);
	import keyboardPkg::*;

	localparam int FRAME_BITS = $bits(ps2Frame);  // 11
	localparam int IDLE_TIMEOUT = 2000;           // Clocks without an edge
	localparam int IDLE_W = $clog2(IDLE_TIMEOUT);

	logic [2:0] ps2cSync;       // Three-stage synchroniser
	logic [2:0] ps2DataSync;
	logic ps2cLast;             // Delayed copy for edge detect
	logic fallEdge;
	logic lastBit;              // Stop bit is on the wire
	logic [3:0] bitCount;       // Bits taken so far
	logic [IDLE_W-1:0] idleCount;
	ps2Frame frame;
	ps2Frame nextFrame;

	always_ff @(posedge CLK) begin
		if (reset) begin
			ps2cSync <= '1;      // Lines idle high
			ps2DataSync <= '1;
			ps2cLast <= 1'b1;
		end else begin
			ps2cSync <= {ps2cSync[1:0], ps2c};
			ps2DataSync <= {ps2DataSync[1:0], ps2Data};
			ps2cLast <= ps2cSync[2];
		end
	end

	assign fallEdge = ps2cLast & ~ps2cSync[2];
	assign lastBit = (bitCount == 4'(FRAME_BITS - 1));
	assign nextFrame = ps2Frame'({ps2DataSync[2], frame[FRAME_BITS-1:1]});  // Shift in at MSB

	// Frame shifter and code output
	always_ff @(posedge CLK) begin
		if (fallEdge) begin
			frame <= nextFrame;
			if (lastBit) begin
				keyCode <= nextFrame.data;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			bitCount <= '0;
			idleCount <= '0;
			keyValid <= 1'b0;
		end else begin
			keyValid <= 1'b0;                          // Default no pulse
			if (fallEdge) begin
				idleCount <= '0;
				if (lastBit) begin
					bitCount <= '0;
					keyValid <= frameValid(nextFrame);    // Bad frames dropped
				end else begin
					bitCount <= bitCount + 4'd1;
				end
			end else if (bitCount != '0) begin
				if (idleCount == IDLE_W'(IDLE_TIMEOUT - 1)) begin
					bitCount <= '0;                       // Abandon partial frame
					idleCount <= '0;
				end else begin
					idleCount <= idleCount + 1'b1;
				end
			end
		end
	end

endmodule

// ==== verilog/keyFifo.sv ====
// Scan-code FIFO
`timescale 1ns/1ps
`include "console_config.svh"

module keyFifo #(
	parameter int DEPTH = `KEY_FIFO_DEPTH  // Power of two
) (
	input logic CLK,
	input logic reset,
	input logic pushKey,
	input keyboardPkg::scanCode pushCode,
	input logic popKey,
	output keyboardPkg::scanCode headCode,  // Oldest entry
	output logic empty
);
	import keyboardPkg::*;

	localparam int PTR_W = $clog2(DEPTH);

	scanCode mem [DEPTH];
	logic [PTR_W-1:0] readPtr;
	logic [PTR_W-1:0] writePtr;
	logic [PTR_W:0] fillCount;   // One extra bit for full
	logic doPush;
	logic doPop;

	assign doPush = pushKey && (fillCount != (PTR_W + 1)'(DEPTH));  // Drop when full
	assign doPop = popKey && (fillCount != '0);
	assign empty = (fillCount == '0);
	assign headCode = mem[readPtr];

	always_ff @(posedge CLK) begin
		if (doPush) begin
			mem[writePtr] <= pushCode;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			readPtr <= '0;
			writePtr <= '0;
			fillCount <= '0;
		end else begin
			if (doPush) begin
				writePtr <= writePtr + 1'b1;  // Wraps at DEPTH
			end
			if (doPop) begin
				readPtr <= readPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10: fillCount <= fillCount + 1'b1;
				2'b01: fillCount <= fillCount - 1'b1;
				default: fillCount <= fillCount;    // Both or neither
			endcase
		end
	end

endmodule

// ==== verilog/portRegisters.sv ====
// Processor port registers
`timescale 1ns/1ps
`include "console_config.svh"

module portRegisters (
	input logic CLK,
	input logic reset,
	input logic [7:0] portId,                      // Processor port address
	input logic [7:0] outPort,                     // Processor write data
	input logic writeStrobe,
	input logic keyRequest,                        // Processor wants a key
	input logic empty,                             // FIFO has nothing
	input keyboardPkg::scanCode headCode,
	output logic popKey,
	output keyboardPkg::scanCode keyOut,
	output displayPkg::colorByte displayColor,
	output keyboardPkg::scanCode lastKey           // Copy for the screen
);
	import displayPkg::*;

	logic colorWrite;

	assign popKey = keyRequest && !empty;  // Same edge as the latch
	assign colorWrite = writeStrobe && (portId == `COLOR_PORT);

	// Colour register
	always_ff @(posedge CLK) begin
		if (reset) begin
			displayColor <= '0;
		end else if (colorWrite) begin
			displayColor <= colorByte'(outPort);
		end
	end

	// Key registers take the FIFO head on a pop
	always_ff @(posedge CLK) begin
		if (reset) begin
			keyOut <= '0;
			lastKey <= '0;
		end else if (popKey) begin
			keyOut <= headCode;
			lastKey <= headCode;
		end
	end

endmodule

// ==== verilog/vgaSync.sv ====
// VGA timing and pixel colour
`timescale 1ns/1ps
`include "console_config.svh"

module vgaSync (
	input logic CLK,
	input logic reset,
	input displayPkg::colorByte displayColor,  // Left half
	input keyboardPkg::scanCode lastKey,       // Right half
	output logic HS,                           // Active low
	output logic VS,                           // Active low
	output displayPkg::rgbColor RGB
);
	import displayPkg::*;

	localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;  // 800
	localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;  // 525
	localparam int H_SYNC_START = `H_VISIBLE + `H_FRONT;
	localparam int H_SYNC_END = H_SYNC_START + `H_SYNC;
	localparam int V_SYNC_START = `V_VISIBLE + `V_FRONT;
	localparam int V_SYNC_END = V_SYNC_START + `V_SYNC;
	localparam int DIV_W = $clog2(`PIXEL_DIVIDE);

	logic [DIV_W-1:0] divCount;
	logic pixelTick;     // One clock per pixel
	hCount hPos;
	vCount vPos;
	logic lineEnd;
	logic visible;
	logic hSyncOn;
	logic vSyncOn;

	assign pixelTick = (divCount == DIV_W'(`PIXEL_DIVIDE - 1));
	assign lineEnd = (hPos == hCount'(H_TOTAL - 1));
	assign visible = (hPos < hCount'(`H_VISIBLE)) && (vPos < vCount'(`V_VISIBLE));
	assign hSyncOn = (hPos >= hCount'(H_SYNC_START)) && (hPos < hCount'(H_SYNC_END));
	assign vSyncOn = (vPos >= vCount'(V_SYNC_START)) && (vPos < vCount'(V_SYNC_END));

	always_ff @(posedge CLK) begin
		if (reset) begin
			divCount <= '0;
			hPos <= '0;
			vPos <= '0;
		end else begin
			divCount <= pixelTick ? '0 : divCount + 1'b1;
			if (pixelTick) begin
				hPos <= lineEnd ? '0 : hPos + 1'b1;
				if (lineEnd) begin
					vPos <= (vPos == vCount'(V_TOTAL - 1)) ? '0 : vPos + 1'b1;
				end
			end
		end
	end

	// Registered outputs
	always_ff @(posedge CLK) begin
		if (reset) begin
			HS <= 1'b1;
			VS <= 1'b1;
			RGB <= '0;
		end else begin
			HS <= !hSyncOn;
			VS <= !vSyncOn;
			if (!visible) begin
				RGB <= '0;                                   // Blanking
			end else if (hPos < hCount'(`H_VISIBLE / 2)) begin
				RGB <= expandColor(displayColor);
			end else begin
				RGB <= expandColor(colorByte'(lastKey));     // Key code as colour
			end
		end
	end

endmodule

// ==== verilog/alarmTone.sv ====
// Alarm square wave
`timescale 1ns/1ps
`include "console_config.svh"

module alarmTone (
	input logic CLK,
	input logic reset,
	input logic alarm,      // Tone while high
	output logic speaker
);
	localparam int HALF = `TONE_HALF_PERIOD;
	localparam int CNT_W = $clog2(HALF);

	logic [CNT_W-1:0] halfCount;
	logic toneTick;          // Clock enable at each half period

	assign toneTick = (halfCount == CNT_W'(HALF - 1));

	always_ff @(posedge CLK) begin
		if (reset || !alarm) begin
			halfCount <= '0;     // Silent and rearmed
			speaker <= 1'b0;
		end else if (toneTick) begin
			halfCount <= '0;
			speaker <= ~speaker;
		end else begin
			halfCount <= halfCount + 1'b1;
		end
	end

endmodule

// ==== verilog/consoleTop.sv ====
// Keyboard and display console
`timescale 1ns/1ps

module consoleTop (
	input logic CLK,
	input logic reset,
	input logic [7:0] portId,
	input logic [7:0] outPort,
	input logic writeStrobe,
	input logic keyRequest,
	input logic ps2c,
	input logic ps2Data,
	input logic alarm,
	output keyboardPkg::scanCode keyOut,
	output displayPkg::rgbColor RGB,
	output logic HS,
	output logic VS,
	output logic speaker
);
	import keyboardPkg::*;
	import displayPkg::*;

	logic keyValid;           // Receiver to FIFO
	scanCode keyCode;
	logic popKey;             // Port block to FIFO
	scanCode headCode;
	logic fifoEmpty;
	colorByte displayColor;   // Port block to display
	scanCode lastKey;

	ps2Receiver receiver (
		.CLK(CLK),
		.reset(reset),
		.ps2c(ps2c),
		.ps2Data(ps2Data),
		.keyValid(keyValid),
		.keyCode(keyCode)
	);

	keyFifo fifo (
		.CLK(CLK),
		.reset(reset),
		.pushKey(keyValid),
		.pushCode(keyCode),
		.popKey(popKey),
		.headCode(headCode),
		.empty(fifoEmpty)
	);

	portRegisters ports (
		.CLK(CLK),
		.reset(reset),
		.portId(portId),
		.outPort(outPort),
		.writeStrobe(writeStrobe),
		.keyRequest(keyRequest),
		.empty(fifoEmpty),
		.headCode(headCode),
		.popKey(popKey),
		.keyOut(keyOut),
		.displayColor(displayColor),
		.lastKey(lastKey)
	);

	vgaSync vga (
		.CLK(CLK),
		.reset(reset),
		.displayColor(displayColor),
		.lastKey(lastKey),
		.HS(HS),
		.VS(VS),
		.RGB(RGB)
	);

	alarmTone tone (
		.CLK(CLK),
		.reset(reset),
		.alarm(alarm),
		.speaker(speaker)
	);

endmodule

// ==== testbench/consoleTb.sv ====
// Console directed testbench
`timescale 1ns/1ps
`include "console_config.svh"

module consoleTb;
	import keyboardPkg::*;
	import displayPkg::*;

	localparam int DEPTH = `KEY_FIFO_DEPTH;
	localparam int HALF = `TONE_HALF_PERIOD;
	localparam int PS2_HALF = 40;                  // Clocks per PS/2 clock phase
	localparam int LINE_PIXELS = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int LINE_CYCLES = LINE_PIXELS * `PIXEL_DIVIDE;
	localparam int FRAME_LINES = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int FRAME_CYCLES = FRAME_LINES * LINE_CYCLES;
	localparam int LEFT_WAIT = (`H_BACK + 100) * `PIXEL_DIVIDE + 1;  // HS rise to pixel 100
	localparam int RIGHT_WAIT = 400 * `PIXEL_DIVIDE;                 // Pixel 100 to pixel 500
	localparam int SEL_HS = 0;
	localparam int SEL_VS = 1;
	localparam int SEL_SPEAKER = 2;

	logic CLK;
	logic reset;
	logic [7:0] portId;
	logic [7:0] outPort;
	logic writeStrobe;
	logic keyRequest;
	logic ps2c;
	logic ps2Data;
	logic alarm;
	scanCode keyOut;
	rgbColor RGB;
	logic HS;
	logic VS;
	logic speaker;

	int errors;           // Failed compares
	int timeouts;         // Expired waits
	scanCode expectKey;   // Model of keyOut and lastKey

	consoleTop UUT (
		.CLK(CLK),
		.reset(reset),
		.portId(portId),
		.outPort(outPort),
		.writeStrobe(writeStrobe),
		.keyRequest(keyRequest),
		.ps2c(ps2c),
		.ps2Data(ps2Data),
		.alarm(alarm),
		.keyOut(keyOut),
		.RGB(RGB),
		.HS(HS),
		.VS(VS),
		.speaker(speaker)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;   // 4 ns period
	end

	// RRRGGGBB to 4-bit channels, MSB of each field fills the low bits
	function automatic rgbColor widenByte(logic [7:0] b);
		rgbColor c;
		c.red = {b[7:5], b[7]};
		c.green = {b[4:2], b[4]};
		c.blue = {b[1:0], {2{b[1]}}};
		return c;
	endfunction

	function automatic logic probe(int which);
		case (which)
			SEL_HS: return HS;
			SEL_VS: return VS;
			default: return speaker;
		endcase
	endfunction

	task automatic checkKey(input scanCode actual, input scanCode expected, input string what);
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0d ns: %s, keyOut %h, expected %h", $time, what, actual,
				expected);
		end
	endtask

	task automatic checkColor(input rgbColor actual, input rgbColor expected, input string what);
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0d ns: %s, RGB %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic checkBit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0d ns: %s, got %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic checkCount(input int actual, input int expected, input string what);
		if (actual != expected) begin
			errors++;
			$display("** Error at %0d ns: %s, %0d cycles, expected %0d", $time, what, actual,
				expected);
		end
	endtask

	// Counts falling edges until the signal reaches level
	task automatic waitLevel(input int which, input logic level, input int limit,
		input string name, output int cycles);
		cycles = 0;
		while (probe(which) !== level && cycles < limit) begin
			@(negedge CLK);
			cycles++;
		end
		if (probe(which) !== level) begin
			timeouts++;
			$display("Timed out after %0d cycles waiting for %s to go %b", limit, name, level);
		end
	endtask

	// Start, data LSB first, odd parity, stop
	task automatic sendFrame(input scanCode code, input logic badParity);
		logic [10:0] bits;
		int i;
		bits = {1'b1, (~^code) ^ badParity, code, 1'b0};
		for (i = 0; i < 11; i++) begin
			ps2Data = bits[i];           // Set up while ps2c is high
			repeat (PS2_HALF) @(negedge CLK);
			ps2c = 1'b0;
			repeat (PS2_HALF) @(negedge CLK);
			ps2c = 1'b1;
		end
		ps2Data = 1'b1;
		repeat (PS2_HALF) @(negedge CLK);  // Line idle
	endtask

	task automatic requestKey();
		keyRequest = 1'b1;
		@(negedge CLK);
		keyRequest = 1'b0;
	endtask

	task automatic writePort(input logic [7:0] addr, input logic [7:0] data);
		portId = addr;
		outPort = data;
		writeStrobe = 1'b1;
		@(negedge CLK);
		writeStrobe = 1'b0;
	endtask

	task automatic testReset();
		int n;
		checkKey(keyOut, 8'h00, "keyOut after reset");
		checkBit(speaker, 1'b0, "speaker after reset");
		waitLevel(SEL_HS, 1'b0, LINE_CYCLES, "HS", n);
		checkColor(RGB, rgbColor'(12'h000), "RGB in blanking");
	endtask

	task automatic testSingleKey();
		scanCode code;
		code = scanCode'($urandom);
		sendFrame(code, 1'b0);
		repeat (4) @(negedge CLK);
		requestKey();
		expectKey = code;
		checkKey(keyOut, expectKey, "single key");
		requestKey();
		checkKey(keyOut, expectKey, "request on empty FIFO");
	endtask

	task automatic testParityOverflow();
		scanCode sent [DEPTH+2];
		int i;
		sendFrame(scanCode'($urandom), 1'b1);  // Must be dropped
		repeat (4) @(negedge CLK);
		requestKey();
		checkKey(keyOut, expectKey, "bad parity frame");
		for (i = 0; i < DEPTH + 2; i++) begin
			sent[i] = scanCode'($urandom_range(255, 1));  // Nonzero key colour
			sendFrame(sent[i], 1'b0);
		end
		for (i = 0; i < DEPTH + 1; i++) begin
			requestKey();
			if (i < DEPTH) begin
				expectKey = sent[i];             // Last request finds it empty
			end
			checkKey(keyOut, expectKey, "FIFO order");
		end
	endtask

	task automatic testDisplay();
		logic [7:0] color;
		int n;
		color = 8'($urandom);
		writePort(`COLOR_PORT, color);
		writePort(`COLOR_PORT + 8'h01, ~color);  // Other port ignored
		waitLevel(SEL_HS, 1'b0, LINE_CYCLES, "HS", n);
		checkColor(RGB, rgbColor'(12'h000), "RGB in blanking with key shown");
		waitLevel(SEL_HS, 1'b1, LINE_CYCLES, "HS", n);
		repeat (LEFT_WAIT) @(negedge CLK);
		checkColor(RGB, widenByte(color), "left half colour");
		repeat (RIGHT_WAIT) @(negedge CLK);
		checkColor(RGB, widenByte(expectKey), "right half key colour");
	endtask

	task automatic testSyncPeriods();
		int a;
		int b;
		waitLevel(SEL_HS, 1'b1, LINE_CYCLES, "HS", a);
		waitLevel(SEL_HS, 1'b0, LINE_CYCLES, "HS", a);  // At a falling edge
		waitLevel(SEL_HS, 1'b1, LINE_CYCLES, "HS", a);
		waitLevel(SEL_HS, 1'b0, LINE_CYCLES, "HS", b);
		checkCount(a, `H_SYNC * `PIXEL_DIVIDE, "HS low time");
		checkCount(a + b, LINE_CYCLES, "HS period");
		waitLevel(SEL_VS, 1'b1, FRAME_CYCLES, "VS", a);
		waitLevel(SEL_VS, 1'b0, FRAME_CYCLES, "VS", a);
		waitLevel(SEL_VS, 1'b1, 3 * LINE_CYCLES, "VS", b);
		checkCount(b, `V_SYNC * LINE_CYCLES, "VS low time");
	endtask

	task automatic testAlarm();
		int n;
		int i;
		alarm = 1'b1;
		waitLevel(SEL_SPEAKER, 1'b1, 4 * HALF, "speaker", n);
		waitLevel(SEL_SPEAKER, 1'b0, 4 * HALF, "speaker", n);
		checkCount(n, HALF, "speaker high half");
		waitLevel(SEL_SPEAKER, 1'b1, 4 * HALF, "speaker", n);
		checkCount(n, HALF, "speaker low half");
		alarm = 1'b0;                          // Drop while speaker is high
		@(negedge CLK);
		checkBit(speaker, 1'b0, "speaker after alarm off");
		for (i = 0; i < 4 * HALF; i++) begin
			@(negedge CLK);
			checkBit(speaker, 1'b0, "speaker silent");
		end
	endtask

	initial begin
		void'($urandom(32'h7f3605c0));
		errors = 0;
		timeouts = 0;
		expectKey = '0;
		reset = 1'b1;
		portId = '0;
		outPort = '0;
		writeStrobe = 1'b0;
		keyRequest = 1'b0;
		ps2c = 1'b1;                           // PS/2 lines idle high
		ps2Data = 1'b1;
		alarm = 1'b0;
		repeat (4) @(negedge CLK);
		reset = 1'b0;
		testReset();
		testSingleKey();
		testParityOverflow();
		testDisplay();
		testSyncPeriods();
		testAlarm();
		$display("Compare errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+include
verilog/keyboardPkg.sv
verilog/displayPkg.sv
verilog/ps2Receiver.sv
verilog/keyFifo.sv
verilog/portRegisters.sv
verilog/vgaSync.sv
verilog/alarmTone.sv
verilog/consoleTop.sv
testbench/consoleTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP = consoleTb
FILELIST = files.f
OBJ_DIR = obj_dir
PASS_TEXT = SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
